// File: frv_regfile_top.f
source/frv_arch_pkg.sv
source/frv_pipe_pkg.sv
source/frv_gpr_rd_if.sv
source/frv_gpr_wr_if.sv
source/frv_gprs.sv
source/frv_writeback.sv
source/frv_operand_fetch.sv
source/frv_regfile_top.sv
sim/frv_regfile_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the register file testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f frv_regfile_top.f \
    --top-module frv_regfile_tb -o frv_regfile_sim || { echo "Build failed"; exit 1; }
out=$(./obj_dir/frv_regfile_sim 2>&1)
echo "$out"
echo "$out" | grep -q "Simulation PASSED" && exit 0 || exit 1

// File: sim/frv_regfile_tb.sv
// Self-checking testbench for the register file slice.
// Drives writebacks and issues into frv_regfile_top, keeps a reference copy
// of the 32 architectural registers and checks every operand bundle.
// Compile with the project file list and use frv_regfile_tb as top module.

`timescale 1ns/1ps
`default_nettype none

module frv_regfile_tb;

    localparam int RST_CYCLES  = 16;
    localparam int DIR_CYCLES  = 300;   // Upper bound of the directed part
    localparam int RAND_CYCLES = 4000;
    localparam int TIMEOUT_NS  = (RST_CYCLES + DIR_CYCLES + RAND_CYCLES) * 10 + 2000;

    logic                    g_clk = 1'b0;
    logic                    rst;
    logic                    wb_valid;
    logic                    wb_wide;
    logic                    wb_hi_rev;
    frv_arch_pkg::reg_addr_t wb_rd;
    frv_arch_pkg::pair_t     wb_result;
    logic                    issue_valid;
    frv_arch_pkg::reg_addr_t rs1_addr;
    frv_arch_pkg::reg_addr_t rs2_addr;
    frv_arch_pkg::reg_addr_t rs3_addr;
    logic                    opr_valid;
    frv_arch_pkg::pair_t     opr_a;
    frv_arch_pkg::pair_t     opr_b;
    frv_arch_pkg::xword_t    opr_c;

    frv_arch_pkg::xword_t arch [32];    // Architectural register values
    frv_arch_pkg::pair_t  exp_a [$];
    frv_arch_pkg::pair_t  exp_b [$];
    frv_arch_pkg::xword_t exp_c [$];
    logic                 valid_exp;    // opr_valid expected in this cycle
    logic                 checking = 1'b0;
    logic [31:0]          lcg_state = 32'hd19d67ac;

    frv_regfile_top UUT (
        .g_clk       (g_clk),
        .rst         (rst),
        .wb_valid    (wb_valid),
        .wb_wide     (wb_wide),
        .wb_hi_rev   (wb_hi_rev),
        .wb_rd       (wb_rd),
        .wb_result   (wb_result),
        .issue_valid (issue_valid),
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .rs3_addr    (rs3_addr),
        .opr_valid   (opr_valid),
        .opr_a       (opr_a),
        .opr_b       (opr_b),
        .opr_c       (opr_c)
    );

    always #5 g_clk = ~g_clk;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic frv_arch_pkg::xword_t reverse_bits(input frv_arch_pkg::xword_t w);
        frv_arch_pkg::xword_t r;
        for (int i = 0; i < 32; i++) begin
            r[i] = w[31-i];
        end
        return r;
    endfunction

    // Odd register of the pair in the high word and the addressed register below
    function automatic frv_arch_pkg::pair_t expect_pair(input frv_arch_pkg::reg_addr_t rs);
        return {arch[{rs[4:1], 1'b1}], arch[rs]};
    endfunction

    task automatic apply_write(input logic wide, input logic hi_rev,
                               input frv_arch_pkg::reg_addr_t rd,
                               input frv_arch_pkg::pair_t res);
        if (wide) begin
            if (rd != 5'd0) begin
                arch[rd] = res[31:0];
            end
            arch[rd | 5'd1] = hi_rev ? reverse_bits(res[63:32]) : res[63:32];
        end else if (rd[0]) begin
            arch[rd] = hi_rev ? reverse_bits(res[31:0]) : res[31:0];
        end else if (rd != 5'd0) begin
            arch[rd] = res[31:0];  // x0 keeps reading zero
        end
    endtask

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("mismatch at time %0t: %s got %h expected %h", $time, what, actual, expected);
            $display("Simulation FAILED");
            $fatal(1, "stopped at first error");
        end
    endtask

    // One clock cycle of stimulus where an issue sees the model before this cycle's write
    task automatic step(input logic wv, input logic wide, input logic hi_rev,
                        input frv_arch_pkg::reg_addr_t rd, input frv_arch_pkg::pair_t res,
                        input logic iv, input frv_arch_pkg::reg_addr_t r1,
                        input frv_arch_pkg::reg_addr_t r2, input frv_arch_pkg::reg_addr_t r3);
        @(posedge g_clk);
        if (iv) begin
            exp_a.push_back(expect_pair(r1));
            exp_b.push_back(expect_pair(r2));
            exp_c.push_back(arch[r3]);
        end
        if (wv) begin
            apply_write(wide, hi_rev, rd, res);
        end
        wb_valid    <= wv;
        wb_wide     <= wide;
        wb_hi_rev   <= hi_rev;
        wb_rd       <= rd;
        wb_result   <= res;
        issue_valid <= iv;
        rs1_addr    <= r1;
        rs2_addr    <= r2;
        rs3_addr    <= r3;
    endtask

    task automatic write_only(input logic wide, input logic hi_rev,
                              input frv_arch_pkg::reg_addr_t rd, input frv_arch_pkg::pair_t res);
        step(1'b1, wide, hi_rev, rd, res, 1'b0, 5'd0, 5'd0, 5'd0);
    endtask

    task automatic issue_only(input frv_arch_pkg::reg_addr_t r1,
                              input frv_arch_pkg::reg_addr_t r2,
                              input frv_arch_pkg::reg_addr_t r3);
        step(1'b0, 1'b0, 1'b0, 5'd0, '0, 1'b1, r1, r2, r3);
    endtask

    task automatic idle();
        step(1'b0, 1'b0, 1'b0, 5'd0, '0, 1'b0, 5'd0, 5'd0, 5'd0);
    endtask

    // A result is due one cycle after each sampled issue
    always @(posedge g_clk) begin
        valid_exp <= !rst && issue_valid;
    end

    always @(negedge g_clk) begin
        if (checking) begin
            check_value({63'd0, opr_valid}, {63'd0, valid_exp}, "opr_valid");
            if (opr_valid) begin
                check_value(opr_a, exp_a.pop_front(), "opr_a");
                check_value(opr_b, exp_b.pop_front(), "opr_b");
                check_value({32'd0, opr_c}, {32'd0, exp_c.pop_front()}, "opr_c");
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Error: run timed out after %0d ns", TIMEOUT_NS);
        $display("Simulation FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        frv_arch_pkg::pair_t     res;
        frv_arch_pkg::reg_addr_t rd;
        logic [31:0]             c;
        logic [31:0]             a;
        rst         = 1'b1;
        wb_valid    = 1'b0;
        wb_wide     = 1'b0;
        wb_hi_rev   = 1'b0;
        wb_rd       = '0;
        wb_result   = '0;
        issue_valid = 1'b0;
        rs1_addr    = '0;
        rs2_addr    = '0;
        rs3_addr    = '0;
        arch[0]     = '0;
        repeat (RST_CYCLES) @(posedge g_clk);
        rst      <= 1'b0;
        checking <= 1'b1;
        repeat (4) idle();  // opr_valid stays low without issues

        // Narrow values everywhere and then read back
        for (int i = 0; i < 32; i++) begin
            write_only(1'b0, 1'b0, 5'(i), {next_rand(), next_rand()});
        end
        for (int i = 0; i < 32; i++) begin
            issue_only(5'(i), 5'(31 - i), 5'(i));
        end
        write_only(1'b0, 1'b0, 5'd0, 64'hffff_ffff_ffff_ffff);
        issue_only(5'd0, 5'd0, 5'd0);

        // Wide writes to every pair
        for (int i = 0; i < 16; i++) begin
            write_only(1'b1, 1'b0, 5'(2 * i), {next_rand(), next_rand()});
        end
        for (int i = 0; i < 16; i++) begin
            issue_only(5'(2 * i), 5'(2 * i + 1), 5'(2 * i + 1));
        end

        // Reversed odd storage through wide and narrow writes
        for (int i = 0; i < 16; i++) begin
            write_only(i % 2 == 0, 1'b1, 5'(2 * i + i % 2), {next_rand(), next_rand()});
            write_only(1'b0, 1'b1, 5'(2 * i), {next_rand(), next_rand()});  // Even write keeps flag
        end
        for (int i = 0; i < 16; i++) begin
            issue_only(5'(2 * i + 1), 5'(2 * i), 5'(2 * i));
        end

        // A same-cycle issue sees the old value and the next one hits the bypass
        for (int i = 0; i < 16; i++) begin
            res = {next_rand(), next_rand()};
            step(1'b1, 1'b1, 1'b1, 5'(2 * i), res, 1'b1, 5'(2 * i), 5'(2 * i + 1), 5'(2 * i + 1));
            issue_only(5'(2 * i), 5'(2 * i + 1), 5'(2 * i + 1));
            res = {next_rand(), next_rand()};
            step(1'b1, 1'b0, 1'b1, 5'(2 * i + 1), res, 1'b1, 5'(2 * i + 1), 5'(2 * i), 5'(2 * i + 1));
            issue_only(5'(2 * i + 1), 5'(2 * i), 5'(2 * i + 1));
        end

        for (int n = 0; n < RAND_CYCLES; n++) begin
            c  = next_rand();
            a  = next_rand();
            rd = c[26:22];
            if (c[30]) begin
                rd[0] = 1'b0;  // Pair writes target the even register
            end
            res = {next_rand(), next_rand()};
            step(c[31], c[30], c[29], rd, res, c[28] | c[27], a[31:27], a[26:22], a[21:17]);
        end

        idle();
        for (int k = 0; k < 10 && exp_a.size() != 0; k++) begin
            @(posedge g_clk);
        end
        @(posedge g_clk);
        if (exp_a.size() != 0) begin
            $display("Error: %0d issues never returned operands", exp_a.size());
            $display("Simulation FAILED");
            $fatal(1, "operands missing");
        end else begin
            $display("Simulation PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: source/frv_arch_pkg.sv
// Architectural types of the register file slice.
// Register numbers, pair indices and data words are shared by every RTL block
// and by the testbench reference model.

`default_nettype none

package frv_arch_pkg;

    // Register number x0..x31
    typedef logic [4:0] reg_addr_t;

    // Even/odd pair index, the register number without its low bit
    typedef logic [3:0] bank_idx_t;

    // One architectural register value
    typedef logic [31:0] xword_t;

    // Wide result, high word goes to the odd register of the pair
    typedef logic [63:0] pair_t;

    localparam int NUM_PAIRS = 16;  // 32 registers as even/odd pairs

endpackage

`default_nettype wire

// File: source/frv_gpr_rd_if.sv
// One read port of the general purpose register file.
// The reader drives addr, the register file returns the addressed word,
// the odd word of the pair and the reversal flags of both.

`timescale 1ns/1ps
`default_nettype none

interface frv_gpr_rd_if;

    frv_arch_pkg::reg_addr_t addr;    // Source register
    frv_arch_pkg::xword_t    data;    // Addressed register as stored
    frv_arch_pkg::xword_t    rdhi;    // Odd register of the pair as stored
    logic                    lo_rev;  // data is bit-reversed
    logic                    hi_rev;  // rdhi is bit-reversed

    modport regfile (input addr, output data, output rdhi, output lo_rev, output hi_rev);

    modport reader (output addr, input data, input rdhi, input lo_rev, input hi_rev);

endinterface

`default_nettype wire

// File: source/frv_gpr_wr_if.sv
// Register file write port.
// One strobe writes a single register, or with wide set an even/odd pair.
// The odd word may be delivered bit-reversed and is flagged as such.

`timescale 1ns/1ps
`default_nettype none

interface frv_gpr_wr_if;

    logic                    wen;           // Write strobe
    logic                    wide;          // Fill the whole even/odd pair
    frv_arch_pkg::reg_addr_t addr;          // Destination register
    frv_arch_pkg::xword_t    wdata;         // Low word, or the narrow value
    frv_arch_pkg::xword_t    wdata_hi;      // High word of a wide write
    logic                    wdata_hi_rev;  // Odd word is in reversed form

    modport writer (
        output wen,
        output wide,
        output addr,
        output wdata,
        output wdata_hi,
        output wdata_hi_rev
    );

    // Also used by operand fetch to snoop writes in flight
    modport regfile (
        input wen,
        input wide,
        input addr,
        input wdata,
        input wdata_hi,
        input wdata_hi_rev
    );

endinterface

`default_nettype wire

// File: source/frv_gprs.sv
// General purpose register file, stored as an even and an odd bank.
// Three combinational read ports and one write port that can fill a pair.
// Every odd register carries a flag telling that it is held bit-reversed.

`timescale 1ns/1ps
`default_nettype none

module frv_gprs (
    input  logic          g_clk,
    frv_gpr_rd_if.regfile rd1,
    frv_gpr_rd_if.regfile rd2,
    frv_gpr_rd_if.regfile rd3,
    frv_gpr_wr_if.regfile wr
);

    // x0 has no storage, pair 0 starts at the odd bank
    frv_arch_pkg::xword_t even_q [1:frv_arch_pkg::NUM_PAIRS-1];
    frv_arch_pkg::xword_t odd_q  [frv_arch_pkg::NUM_PAIRS];
    logic [frv_arch_pkg::NUM_PAIRS-1:0] rev_q;  // Odd register held reversed

    frv_arch_pkg::xword_t even_rd [frv_arch_pkg::NUM_PAIRS];

    frv_arch_pkg::bank_idx_t wr_pair;
    logic                    wr_even;
    logic                    wr_odd;
    frv_arch_pkg::xword_t    wdata_odd;

    assign wr_pair   = wr.addr[4:1];
    assign wr_even   = wr.wen && !wr.addr[0];
    assign wr_odd    = wr.wen && (wr.addr[0] || wr.wide);  // Wide writes touch both halves
    assign wdata_odd = wr.wide ? wr.wdata_hi : wr.wdata;

    always_ff @(posedge g_clk) begin
        for (int p = 1; p < frv_arch_pkg::NUM_PAIRS; p++) begin
            if (wr_even && wr_pair == frv_arch_pkg::bank_idx_t'(p)) begin
                even_q[p] <= wr.wdata;
            end
        end
    end

    always_ff @(posedge g_clk) begin
        for (int p = 0; p < frv_arch_pkg::NUM_PAIRS; p++) begin
            if (wr_odd && wr_pair == frv_arch_pkg::bank_idx_t'(p)) begin
                odd_q[p] <= wdata_odd;
                rev_q[p] <= wr.wdata_hi_rev;  // Flag follows every odd write
            end
        end
    end

    // Even read view with x0 tied to zero
    for (genvar p = 0; p < frv_arch_pkg::NUM_PAIRS; p++) begin : g_even_rd
        if (p == 0) begin : g_zero
            assign even_rd[p] = '0;
        end else begin : g_bank
            assign even_rd[p] = even_q[p];
        end
    end

    // Source 1
    assign rd1.data   = rd1.addr[0] ? odd_q[rd1.addr[4:1]] : even_rd[rd1.addr[4:1]];
    assign rd1.rdhi   = odd_q[rd1.addr[4:1]];
    assign rd1.lo_rev = rd1.addr[0] && rev_q[rd1.addr[4:1]];
    assign rd1.hi_rev = rev_q[rd1.addr[4:1]];

    // Source 2
    assign rd2.data   = rd2.addr[0] ? odd_q[rd2.addr[4:1]] : even_rd[rd2.addr[4:1]];
    assign rd2.rdhi   = odd_q[rd2.addr[4:1]];
    assign rd2.lo_rev = rd2.addr[0] && rev_q[rd2.addr[4:1]];
    assign rd2.hi_rev = rev_q[rd2.addr[4:1]];

    // Source 3, the pair outputs are left to the reader
    assign rd3.data   = rd3.addr[0] ? odd_q[rd3.addr[4:1]] : even_rd[rd3.addr[4:1]];
    assign rd3.rdhi   = odd_q[rd3.addr[4:1]];
    assign rd3.lo_rev = rd3.addr[0] && rev_q[rd3.addr[4:1]];
    assign rd3.hi_rev = rev_q[rd3.addr[4:1]];

    // The writeback stage must never request a pair write to an odd register
    a_wide_even: assert property (@(posedge g_clk) wr.wen && wr.wide |-> !wr.addr[0])
        else $error("wide write with odd destination %0d", wr.addr);

endmodule

`default_nettype wire

// File: source/frv_operand_fetch.sv
// Operand fetch stage.
// Reads three sources, undoes stored bit reversal and bypasses the write
// in flight so the registered operands match the architectural state.
// opr_a/opr_b are {odd pair register, addressed register}, opr_c one word.

`timescale 1ns/1ps
`default_nettype none

module frv_operand_fetch (
    input  logic                    g_clk,
    input  logic                    rst,
    input  logic                    issue_valid,
    input  frv_arch_pkg::reg_addr_t rs1_addr,
    input  frv_arch_pkg::reg_addr_t rs2_addr,
    input  frv_arch_pkg::reg_addr_t rs3_addr,
    frv_gpr_rd_if.reader            rd1,
    frv_gpr_rd_if.reader            rd2,
    frv_gpr_rd_if.reader            rd3,
    frv_gpr_wr_if.regfile           wr,
    output logic                    opr_valid,
    output frv_arch_pkg::pair_t     opr_a,
    output frv_arch_pkg::pair_t     opr_b,
    output frv_arch_pkg::xword_t    opr_c
);

    frv_pipe_pkg::opr_sel_t sel;
    logic                   w_even;    // Write in flight hits an even register
    logic                   w_odd;     // Write in flight hits an odd register
    frv_arch_pkg::xword_t   byp_even;
    frv_arch_pkg::xword_t   byp_odd;   // Architectural value of the odd write
    frv_arch_pkg::xword_t   a_lo;
    frv_arch_pkg::xword_t   a_hi;
    frv_arch_pkg::xword_t   b_lo;
    frv_arch_pkg::xword_t   b_hi;
    frv_arch_pkg::xword_t   c_lo;

    function automatic frv_arch_pkg::xword_t bit_rev(input frv_arch_pkg::xword_t w);
        frv_arch_pkg::xword_t r;
        for (int i = 0; i < $bits(w); i++) begin
            r[i] = w[$bits(w)-1-i];
        end
        return r;
    endfunction

    // Same pair and odd/even rules as the register file, x0 never forwards
    function automatic logic lo_hit(
        input frv_arch_pkg::reg_addr_t a,
        input frv_arch_pkg::reg_addr_t wa,
        input logic                    we,
        input logic                    wo
    );
        return (a != '0) && (a[4:1] == wa[4:1]) && (a[0] ? wo : we);
    endfunction

    function automatic frv_arch_pkg::xword_t fix(
        input logic                 hit,
        input frv_arch_pkg::xword_t byp,
        input frv_arch_pkg::xword_t data,
        input logic                 rev
    );
        if (hit) begin
            return byp;
        end
        return rev ? bit_rev(data) : data;
    endfunction

    assign sel = '{rs1: rs1_addr, rs2: rs2_addr, rs3: rs3_addr};

    assign rd1.addr = sel.rs1;
    assign rd2.addr = sel.rs2;
    assign rd3.addr = sel.rs3;

    assign w_even   = wr.wen && !wr.addr[0];
    assign w_odd    = wr.wen && (wr.addr[0] || wr.wide);
    assign byp_even = wr.wdata;
    assign byp_odd  = fix(1'b0, '0, wr.wide ? wr.wdata_hi : wr.wdata, wr.wdata_hi_rev);

    assign a_lo = fix(lo_hit(sel.rs1, wr.addr, w_even, w_odd),
                      sel.rs1[0] ? byp_odd : byp_even, rd1.data, rd1.lo_rev);
    assign a_hi = fix(w_odd && sel.rs1[4:1] == wr.addr[4:1], byp_odd, rd1.rdhi, rd1.hi_rev);

    assign b_lo = fix(lo_hit(sel.rs2, wr.addr, w_even, w_odd),
                      sel.rs2[0] ? byp_odd : byp_even, rd2.data, rd2.lo_rev);
    assign b_hi = fix(w_odd && sel.rs2[4:1] == wr.addr[4:1], byp_odd, rd2.rdhi, rd2.hi_rev);

    assign c_lo = fix(lo_hit(sel.rs3, wr.addr, w_even, w_odd),
                      sel.rs3[0] ? byp_odd : byp_even, rd3.data, rd3.lo_rev);

    always_ff @(posedge g_clk) begin
        if (rst) begin
            opr_valid <= 1'b0;
        end else begin
            opr_valid <= issue_valid;
        end
    end

    always_ff @(posedge g_clk) begin
        if (issue_valid) begin
            opr_a <= {a_hi, a_lo};
            opr_b <= {b_hi, b_lo};
            opr_c <= c_lo;
        end
    end

    // Exactly one result per issue, one cycle later
    a_one_per_issue: assert property (@(posedge g_clk) !rst |=> opr_valid == $past(issue_valid))
        else $error("opr_valid does not follow issue_valid");

endmodule

`default_nettype wire

// File: source/frv_pipe_pkg.sv
// Pipeline bundle types for the writeback and operand fetch stages.
// Both are packed structs built from the architectural types.

`default_nettype none

package frv_pipe_pkg;

    // Writeback request control held by the writeback register
    typedef struct packed {
        logic                    valid;   // Request will write the register file
        logic                    wide;    // Write a full even/odd pair
        logic                    hi_rev;  // Odd data is stored bit-reversed
        frv_arch_pkg::reg_addr_t rd;      // Destination register
    } wb_ctrl_t;

    // Source selection captured at issue
    typedef struct packed {
        frv_arch_pkg::reg_addr_t rs1;
        frv_arch_pkg::reg_addr_t rs2;
        frv_arch_pkg::reg_addr_t rs3;
    } opr_sel_t;

endpackage

`default_nettype wire

// File: source/frv_regfile_top.sv
// Register file slice top level.
// Joins the writeback stage, the banked register file and operand fetch.
// A write request in cycle N is seen by issues from cycle N+1 onwards.

`timescale 1ns/1ps
`default_nettype none

module frv_regfile_top (
    input  logic                    g_clk,
    input  logic                    rst,
    input  logic                    wb_valid,
    input  logic                    wb_wide,
    input  logic                    wb_hi_rev,
    input  frv_arch_pkg::reg_addr_t wb_rd,
    input  frv_arch_pkg::pair_t     wb_result,
    input  logic                    issue_valid,
    input  frv_arch_pkg::reg_addr_t rs1_addr,
    input  frv_arch_pkg::reg_addr_t rs2_addr,
    input  frv_arch_pkg::reg_addr_t rs3_addr,
    output logic                    opr_valid,
    output frv_arch_pkg::pair_t     opr_a,
    output frv_arch_pkg::pair_t     opr_b,
    output frv_arch_pkg::xword_t    opr_c
);

    frv_gpr_wr_if wr_if ();
    frv_gpr_rd_if rd1_if ();
    frv_gpr_rd_if rd2_if ();
    frv_gpr_rd_if rd3_if ();

    frv_writeback u_writeback (
        .g_clk     (g_clk),
        .rst       (rst),
        .wb_valid  (wb_valid),
        .wb_wide   (wb_wide),
        .wb_hi_rev (wb_hi_rev),
        .wb_rd     (wb_rd),
        .wb_result (wb_result),
        .wr        (wr_if.writer)
    );

    frv_gprs u_gprs (
        .g_clk (g_clk),
        .rd1   (rd1_if.regfile),
        .rd2   (rd2_if.regfile),
        .rd3   (rd3_if.regfile),
        .wr    (wr_if.regfile)
    );

    frv_operand_fetch u_operand_fetch (
        .g_clk       (g_clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .rs3_addr    (rs3_addr),
        .rd1         (rd1_if.reader),
        .rd2         (rd2_if.reader),
        .rd3         (rd3_if.reader),
        .wr          (wr_if.regfile),  // Snoops the write for bypass
        .opr_valid   (opr_valid),
        .opr_a       (opr_a),
        .opr_b       (opr_b),
        .opr_c       (opr_c)
    );

endmodule

`default_nettype wire

// File: source/frv_writeback.sv
// Writeback register stage.
// Captures one result per cycle and presents it as a register file write
// in the following cycle. Narrow writes to x0 are dropped here.

`timescale 1ns/1ps
`default_nettype none

module frv_writeback (
    input  logic                    g_clk,
    input  logic                    rst,
    input  logic                    wb_valid,
    input  logic                    wb_wide,
    input  logic                    wb_hi_rev,
    input  frv_arch_pkg::reg_addr_t wb_rd,
    input  frv_arch_pkg::pair_t     wb_result,
    frv_gpr_wr_if.writer            wr
);

    frv_pipe_pkg::wb_ctrl_t ctrl_q;
    frv_arch_pkg::pair_t    result_q;
    logic                   wb_keep;

    // A wide write to pair 0 still fills x1
    assign wb_keep = wb_valid && (wb_wide || wb_rd != '0);

    always_ff @(posedge g_clk) begin
        if (rst) begin
            ctrl_q <= '0;
        end else begin
            ctrl_q.valid  <= wb_keep;
            ctrl_q.wide   <= wb_wide;
            ctrl_q.hi_rev <= wb_hi_rev;  // Also applies to narrow odd writes
            ctrl_q.rd     <= wb_rd;
        end
    end

    always_ff @(posedge g_clk) begin
        if (wb_valid) begin
            result_q <= wb_result;
        end
    end

    assign wr.wen          = ctrl_q.valid;
    assign wr.wide         = ctrl_q.wide;
    assign wr.addr         = ctrl_q.rd;
    assign wr.wdata        = result_q[31:0];
    assign wr.wdata_hi     = result_q[63:32];  // Odd register of the pair
    assign wr.wdata_hi_rev = ctrl_q.hi_rev;

    // No register file write may come out of a cycle spent in reset
    a_rst_quiet: assert property (@(posedge g_clk) rst |=> !wr.wen)
        else $error("write strobe after reset cycle");

endmodule

`default_nettype wire
